// File: credit_fifo_link.f
design/fifo_pkg.sv
design/link_pkg.sv
design/pipe_delay.sv
design/credit_sender.sv
design/credit_fifo.sv
design/credit_fifo_link.sv
tests/credit_fifo_link_assert.sv
tests/credit_fifo_link_checker.sv
tests/credit_fifo_link_tb.sv

// File: design/credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo #(
  parameter int Depth = 10
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             link_valid,
  input  fifo_pkg::data_t  link_data,
  input  logic             link_credit_stall,
  output logic             link_credit,
  input  logic             pop_ready,
  output logic             pop_valid,
  output fifo_pkg::data_t  pop_data,
  output logic             full,
  output logic             empty,
  output fifo_pkg::count_t items,
  output fifo_pkg::count_t slots
);

  import fifo_pkg::*;

  localparam int AddrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam logic [AddrWidth-1:0] LastAddr = AddrWidth'(Depth - 1);
  localparam count_t DepthCount = count_t'(Depth);

  data_t                mem [Depth];
  logic [AddrWidth-1:0] wr_ptr;
  logic [AddrWidth-1:0] rd_ptr;
  count_t               item_count;
  count_t               credit_owed;
  logic                 pop_fire;
  logic                 credit_release;

  // Flop storage, written on every link beat
  always_ff @(posedge clk) begin
    if (link_valid) begin
      mem[wr_ptr] <= link_data;
    end
  end

  // Head of the queue stays put until it is popped
  assign pop_data  = mem[rd_ptr];
  assign pop_valid = (item_count != '0);
  assign pop_fire  = pop_valid && pop_ready;

  // Pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (link_valid) begin
        wr_ptr <= (wr_ptr == LastAddr) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= (rd_ptr == LastAddr) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      item_count <= '0;
    end else begin
      case ({link_valid, pop_fire})
        2'b10:   item_count <= item_count + 1'b1;
        2'b01:   item_count <= item_count - 1'b1;
        default: item_count <= item_count;
      endcase
    end
  end

  assign items = item_count;
  assign empty = (item_count == '0);
  assign full  = (item_count == DepthCount);
  assign slots = DepthCount - item_count;

  // Release a credit when one is owed or a pop is happening now,
  // never while the far side asks us to hold back
  assign credit_release = !link_credit_stall && ((credit_owed != '0) || pop_fire);

  // Owed count starts at the full depth so the sender gets its initial credit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_owed <= DepthCount;
      link_credit <= 1'b0;
    end else begin
      credit_owed <= credit_owed + count_t'(pop_fire) - count_t'(credit_release);
      link_credit <= credit_release;
    end
  end

endmodule

// File: design/credit_fifo_link.sv
`timescale 1ns/1ps

module credit_fifo_link #(
  parameter int Depth = 10,
  parameter int PropDelay = 3
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push_valid,
  output logic              push_ready,
  input  fifo_pkg::data_t   push_data,
  input  logic              credit_stall,
  output link_pkg::credit_t credit_count,
  input  logic              pop_ready,
  output logic              pop_valid,
  output fifo_pkg::data_t   pop_data,
  output logic              full,
  output logic              empty,
  output fifo_pkg::count_t  items,
  output fifo_pkg::count_t  slots
);

  import fifo_pkg::*;
  import link_pkg::*;

  // Forward beat is valid, data and stall
  localparam int FwdWidth = $bits(data_t) + 2;

  // Full rate needs room for a whole credit round trip
  if (Depth < 2 * PropDelay + 4) begin : gen_depth_check
    $error("Depth %0d too small for PropDelay %0d", Depth, PropDelay);
  end
  if (Depth > MaxDepth) begin : gen_depth_limit
    $error("Depth %0d exceeds %0d", Depth, MaxDepth);
  end
  if (PropDelay < 1 || PropDelay > MaxPropDelay) begin : gen_delay_limit
    $error("PropDelay %0d outside 1..%0d", PropDelay, MaxPropDelay);
  end

  logic  snd_link_valid;
  data_t snd_link_data;
  logic  snd_link_credit_stall;
  logic  snd_link_credit;
  logic  fifo_link_valid;
  data_t fifo_link_data;
  logic  fifo_link_credit_stall;
  logic  fifo_link_credit;

  credit_sender #(
    .Depth(Depth)
  ) u_sender (
    .clk               (clk),
    .rst_n             (rst_n),
    .push_valid        (push_valid),
    .push_ready        (push_ready),
    .push_data         (push_data),
    .credit_stall      (credit_stall),
    .link_valid        (snd_link_valid),
    .link_data         (snd_link_data),
    .link_credit_stall (snd_link_credit_stall),
    .link_credit       (snd_link_credit),
    .credit_count      (credit_count)
  );

  pipe_delay #(
    .PropDelay(PropDelay),
    .Width(FwdWidth)
  ) fwd_delay (
    .clk   (clk),
    .rst_n (rst_n),
    .in    ({snd_link_valid, snd_link_data, snd_link_credit_stall}),
    .out   ({fifo_link_valid, fifo_link_data, fifo_link_credit_stall})
  );

  pipe_delay #(
    .PropDelay(PropDelay),
    .Width(1)
  ) ret_delay (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (fifo_link_credit),
    .out   (snd_link_credit)
  );

  credit_fifo #(
    .Depth(Depth)
  ) u_fifo (
    .clk               (clk),
    .rst_n             (rst_n),
    .link_valid        (fifo_link_valid),
    .link_data         (fifo_link_data),
    .link_credit_stall (fifo_link_credit_stall),
    .link_credit       (fifo_link_credit),
    .pop_ready         (pop_ready),
    .pop_valid         (pop_valid),
    .pop_data          (pop_data),
    .full              (full),
    .empty             (empty),
    .items             (items),
    .slots             (slots)
  );

endmodule

// File: design/credit_sender.sv
`timescale 1ns/1ps

module credit_sender #(
  parameter int Depth = 10
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push_valid,
  output logic              push_ready,
  input  fifo_pkg::data_t   push_data,
  input  logic              credit_stall,
  output logic              link_valid,
  output fifo_pkg::data_t   link_data,
  output logic              link_credit_stall,
  input  logic              link_credit,
  output link_pkg::credit_t credit_count
);

  import link_pkg::*;

  localparam credit_t MaxCredit = credit_t'(Depth);

  credit_t credit_q;
  credit_t credit_next;
  logic    push_accept;

  // One credit is enough to send one byte
  assign push_ready  = (credit_q != '0);
  assign push_accept = push_valid && push_ready;

  // A returned credit and a push in the same cycle cancel out
  always_comb begin
    credit_next = credit_q;
    if (link_credit && !push_accept) begin
      if (credit_q < MaxCredit) begin
        credit_next = credit_q + 1'b1;
      end
    end else if (!link_credit && push_accept) begin
      credit_next = credit_q - 1'b1;
    end
  end

  // Sender starts empty and waits for the far end to hand out credits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_q <= '0;
    end else begin
      credit_q <= credit_next;
    end
  end

  assign credit_count = credit_q;

  // Link control flops
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      link_valid        <= 1'b0;
      link_credit_stall <= 1'b0;
    end else begin
      link_valid        <= push_accept;
      link_credit_stall <= credit_stall;
    end
  end

  // Payload only moves on an accepted push
  always_ff @(posedge clk) begin
    if (push_accept) begin
      link_data <= push_data;
    end
  end

endmodule

// File: design/fifo_pkg.sv
package fifo_pkg;

  // Width of one stored byte
  localparam int DataWidth = 8;

  // Width of item and slot counts
  localparam int CountWidth = 6;

  // Deepest FIFO that CountWidth can describe with margin
  localparam int MaxDepth = 32;

  // One item as pushed, stored and popped
  typedef logic [DataWidth-1:0] data_t;

  // Occupancy, free slots and owed credits
  typedef logic [CountWidth-1:0] count_t;

endpackage

// File: design/link_pkg.sv
package link_pkg;

  // Credit counter width on the sender side
  localparam int CreditWidth = 6;

  // Longest link delay supported, in cycles
  localparam int MaxPropDelay = 8;

  // Credits currently held by the sender
  typedef logic [CreditWidth-1:0] credit_t;

endpackage

// File: design/pipe_delay.sv
`timescale 1ns/1ps

module pipe_delay #(
  parameter int PropDelay = 3,
  parameter int Width = 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [Width-1:0] in,
  output logic [Width-1:0] out
);

  // Stage 0 takes the input, the last stage drives the output
  logic [Width-1:0] stage_q [PropDelay];

  // Cleared chain so no stale valid or credit leaks out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < PropDelay; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= in;
      for (int i = 1; i < PropDelay; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign out = stage_q[PropDelay-1];

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the credit link testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Test failed"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  -f credit_fifo_link.f --top-module credit_fifo_link_tb -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
  exit 1
fi
exit 0

// File: tests/credit_fifo_link_assert.sv
`timescale 1ns/1ps

module credit_fifo_link_assert #(
  parameter int Depth = 10
) (
  input logic             clk,
  input logic             rst_n,
  input logic             link_valid,
  input logic             link_credit_stall,
  input logic             link_credit,
  input logic             pop_valid,
  input logic             pop_ready,
  input logic             full,
  input fifo_pkg::count_t items
);

  // Credits still owed, rebuilt from pops and credit pulses at the ports
  int owed_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owed_q <= Depth;
    end else begin
      owed_q <= owed_q + int'(pop_valid && pop_ready) - int'(link_credit);
    end
  end

  // Every beat on the link was paid for with a free slot
  no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    !(link_valid && full))
    else $error("link_valid arrived while the FIFO was full");

  // A credit held back by the stall still goes out once the stall is low
  held_credit_released: assert property (@(posedge clk) disable iff (!rst_n)
    (!link_credit_stall && owed_q > int'(link_credit)) |=> link_credit)
    else $error("an owed credit was not released while the stall was low");

  items_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    int'(items) <= Depth)
    else $error("items went above the FIFO depth");

endmodule

bind credit_fifo credit_fifo_link_assert #(
  .Depth(Depth)
) u_assert (
  .clk               (clk),
  .rst_n             (rst_n),
  .link_valid        (link_valid),
  .link_credit_stall (link_credit_stall),
  .link_credit       (link_credit),
  .pop_valid         (pop_valid),
  .pop_ready         (pop_ready),
  .full              (full),
  .items             (items)
);

// File: tests/credit_fifo_link_checker.sv
`timescale 1ns/1ps

module credit_fifo_link_checker #(
  parameter int PropDelay = 3
) (
  input logic             clk,
  input logic             rst_n,
  input logic             push_valid,
  input logic             push_ready,
  input fifo_pkg::data_t  push_data,
  input logic             pop_valid,
  input logic             pop_ready,
  input fifo_pkg::data_t  pop_data,
  input fifo_pkg::count_t items
);

  import fifo_pkg::*;

  data_t model_q [$];
  logic  link_q [$];
  int    arrived = 0;
  int    departed = 0;
  string test_name = "reset";
  int    test_errors = 0;
  int    test_pushes = 0;
  int    test_pops = 0;
  int    pass_count = 0;
  int    fail_count = 0;

  // Sampled at the rising edge, before the DUT flops take their new values
  always @(posedge clk) begin
    data_t head;
    if (!rst_n) begin
      model_q.delete();
      link_q.delete();
      arrived  = 0;
      departed = 0;
    end else begin
      if (int'(items) != arrived - departed) begin
        $display("[FAIL] %s: items expected %0d actual %0d", test_name,
                 arrived - departed, items);
        test_errors++;
      end
      if (push_valid && push_ready) begin
        model_q.push_back(push_data);
        test_pushes++;
      end
      if (pop_valid && pop_ready) begin
        if (model_q.size() == 0) begin
          $display("%s: a byte was popped that was never pushed", test_name);
          test_errors++;
        end else begin
          head = model_q.pop_front();
          if (pop_data != head) begin
            $display("[FAIL] %s: pop data expected %02h actual %02h", test_name,
                     head, pop_data);
            test_errors++;
          end
        end
        departed++;
        test_pops++;
      end
      // A pushed byte lands in the FIFO PropDelay + 1 edges after acceptance
      link_q.push_back(push_valid && push_ready);
      if (link_q.size() > PropDelay + 1) begin
        arrived += int'(link_q.pop_front());
      end
    end
  end

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    test_pushes = 0;
    test_pops   = 0;
  endtask

  task automatic check_value(input string what, input int expected, input int actual);
    if (actual != expected) begin
      $display("[FAIL] %s: %s expected %0d actual %0d", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic note_error();
    test_errors++;
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      $display("[PASS] %s", test_name);
      pass_count++;
    end else begin
      $display("[FAIL] %s: errors expected 0 actual %0d", test_name, test_errors);
      fail_count++;
    end
  endtask

endmodule

// File: tests/credit_fifo_link_tb.sv
`timescale 1ns/1ps

module credit_fifo_link_tb;

  import fifo_pkg::*;
  import link_pkg::*;

  localparam int Depth = 10;
  localparam int PropDelay = 3;
  localparam int WaitLimit = 500;

  logic        clk;
  logic        rst_n;
  logic        push_valid;
  logic        push_ready;
  data_t       push_data;
  logic        credit_stall;
  credit_t     credit_count;
  logic        pop_ready;
  logic        pop_valid;
  data_t       pop_data;
  logic        full;
  logic        empty;
  count_t      items;
  count_t      slots;
  logic [15:0] data_lfsr;
  logic [15:0] pop_lfsr;
  logic        aborted;

  credit_fifo_link #(
    .Depth(Depth),
    .PropDelay(PropDelay)
  ) dut (.*);

  credit_fifo_link_checker #(
    .PropDelay(PropDelay)
  ) chk (.*);

  always #4 clk = ~clk;

  // Right-shift Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] galois_step(input logic [15:0] state);
    return (state >> 1) ^ (state[0] ? 16'hB400 : 16'h0000);
  endfunction

  task automatic draw_bits(input int count, inout logic [15:0] state, output data_t bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      state = galois_step(state);
      bits  = {bits[6:0], state[0]};
    end
  endtask

  // Inputs move 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic report_timeout(input string name, input string what);
    $display("Timeout in %s while waiting for %s", name, what);
    chk.note_error();
    aborted = 1'b1;
  endtask

  task automatic wait_credits(input string name, input int target);
    int waited;
    waited = 0;
    while (int'(credit_count) != target && waited < WaitLimit) begin
      next_cycle();
      waited++;
    end
    if (int'(credit_count) != target) report_timeout(name, "credit_count");
  endtask

  task automatic wait_items(input string name, input int target);
    int waited;
    waited = 0;
    while (int'(items) != target && waited < WaitLimit) begin
      next_cycle();
      waited++;
    end
    if (int'(items) != target) report_timeout(name, "items");
  endtask

  task automatic push_bytes(input string name, input int count);
    int    waited;
    data_t value;
    for (int sent = 0; sent < count; sent++) begin
      draw_bits(8, data_lfsr, value);
      push_valid = 1'b1;
      push_data  = value;
      waited = 0;
      while (!push_ready && waited < WaitLimit) begin
        next_cycle();
        waited++;
      end
      if (!push_ready) begin
        report_timeout(name, "push_ready");
        break;
      end
      // Ready is stable here, so the transfer lands on the coming edge
      next_cycle();
    end
    push_valid = 1'b0;
  endtask

  task automatic pop_bytes(input string name, input int count, input string mode);
    int    popped;
    int    waited;
    data_t coin;
    popped = 0;
    waited = 0;
    while (popped < count && waited < WaitLimit) begin
      coin = 8'd1;
      if (mode == "random") draw_bits(1, pop_lfsr, coin);
      pop_ready = coin[0];
      if (pop_ready && pop_valid) begin
        popped++;
        waited = 0;
      end else begin
        waited++;
      end
      next_cycle();
    end
    pop_ready = 1'b0;
    if (popped < count) report_timeout(name, "pop_valid");
  endtask

  task automatic run_test(input string name, input int pushes, input string mode,
                          input int stall_cycles, input int expected);
    int base;
    int held;
    chk.start_test(name);
    if (name == "reset_credit") begin
      chk.check_value("push_ready after reset", 0, int'(push_ready));
      chk.check_value("pop_valid after reset", 0, int'(pop_valid));
      chk.check_value("empty after reset", 1, int'(empty));
      wait_credits(name, Depth);
      chk.check_value("credit_count", expected, int'(credit_count));
      chk.check_value("push_ready", 1, int'(push_ready));
    end else if (name == "ordered" || name == "random_pop") begin
      fork
        push_bytes(name, pushes);
        pop_bytes(name, pushes, mode);
      join
      chk.check_value("bytes popped", expected, chk.test_pops);
      chk.check_value("empty", 1, int'(empty));
    end else if (name == "backpressure") begin
      push_bytes(name, pushes);
      // Offer one more byte that must not be taken
      push_valid = 1'b1;
      repeat (2 * PropDelay + 4) next_cycle();
      push_valid = 1'b0;
      wait_items(name, Depth);
      chk.check_value("bytes accepted", expected, chk.test_pushes);
      chk.check_value("push_ready", 0, int'(push_ready));
      chk.check_value("full", 1, int'(full));
      chk.check_value("items", Depth, int'(items));
      chk.check_value("slots", 0, int'(slots));
      chk.check_value("credit_count", 0, int'(credit_count));
      pop_bytes(name, Depth, "always");
    end else if (name == "credit_stall") begin
      credit_stall = 1'b1;
      push_bytes(name, pushes);
      wait_items(name, pushes);
      base = int'(credit_count);
      pop_bytes(name, pushes, mode);
      held = base;
      for (int i = 0; i < stall_cycles; i++) begin
        if (int'(credit_count) != base) held = int'(credit_count);
        next_cycle();
      end
      chk.check_value("credit_count during stall", base, held);
      credit_stall = 1'b0;
      wait_credits(name, base + expected);
      repeat (2 * PropDelay + 4) next_cycle();
      chk.check_value("credit rise", expected, int'(credit_count) - base);
    end else begin
      $display("Unknown test %s in the trace file", name);
      chk.note_error();
    end
    if (!aborted) begin
      wait_items(name, 0);
      wait_credits(name, Depth);
    end
    chk.finish_test();
  endtask

  initial begin
    int    fd;
    int    fields;
    int    pushes;
    int    stall_cycles;
    int    expected;
    string line;
    string name;
    string mode;
    clk          = 1'b0;
    rst_n        = 1'b0;
    push_valid   = 1'b0;
    push_data    = '0;
    credit_stall = 1'b0;
    pop_ready    = 1'b0;
    data_lfsr    = 16'd43;
    pop_lfsr     = 16'd43;
    aborted      = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    fd = $fopen("tests/credit_fifo_link_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file");
      aborted = 1'b1;
    end
    while (fd != 0 && !aborted && !$feof(fd)) begin
      fields = $fgets(line, fd);
      if (fields > 0 && line.substr(0, 0) != "#") begin
        fields = $sscanf(line, "%s %d %s %d %d", name, pushes, mode, stall_cycles, expected);
        if (fields == 5) begin
          run_test(name, pushes, mode, stall_cycles, expected);
        end else if (fields > 0) begin
          $display("Trace line could not be parsed: %s", line);
          aborted = 1'b1;
        end
      end
    end
    if (fd != 0) $fclose(fd);

    $display("Summary: %0d passed, %0d failed", chk.pass_count, chk.fail_count);
    if (chk.fail_count == 0 && chk.pass_count > 0 && !aborted) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: tests/credit_fifo_link_trace.txt
# test_name push_count pop_ready_mode stall_cycles expected
# expected is the value compared by the test's final check
reset_credit 0 never 0 10
ordered 40 always 0 40
backpressure 10 never 0 10
credit_stall 5 always 20 5
random_pop 60 random 0 60
